// File: Bender.yml
package:
  name: rv_soc

export_include_dirs:
  - src

sources:
  - src/rv_pkg.sv
  - src/fetch_unit.sv
  - src/decoder.sv
  - src/regfile_fwd.sv
  - src/alu.sv
  - src/io_port.sv
  - src/rv_soc.sv
  - target: simulation
    include_dirs:
      - src
      - bench
    files:
      - bench/tb_rv_soc.sv

// File: bench/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

`include "rv_consts.svh"

// RV32I encoders
function automatic rv_pkg::word_t enc_r(input logic [2:0] f3, input logic alt,
                                        input rv_pkg::reg_idx_t rd,
                                        input rv_pkg::reg_idx_t rs1,
                                        input rv_pkg::reg_idx_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV_OP_R};
endfunction

function automatic rv_pkg::word_t enc_i(input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                        input rv_pkg::reg_idx_t rs1, input logic [11:0] imm,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic rv_pkg::word_t enc_u(input logic [6:0] op, input rv_pkg::reg_idx_t rd,
                                        input logic [19:0] imm);
    return {imm, rd, op};
endfunction

function automatic rv_pkg::word_t enc_j(input rv_pkg::reg_idx_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
endfunction

function automatic rv_pkg::word_t enc_b(input logic ne, input rv_pkg::reg_idx_t rs1,
                                        input rv_pkg::reg_idx_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], `RV_OP_BR};
endfunction

function automatic rv_pkg::word_t enc_s(input rv_pkg::reg_idx_t rs1,
                                        input rv_pkg::reg_idx_t rs2, input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], `RV_OP_ST};
endfunction

// hex digit to segments, a on bit 0 through g on bit 6, lit when high
function automatic logic [6:0] seg_code(input logic [3:0] nib);
    case (nib)
        4'h0:    return 7'b0111111;
        4'h1:    return 7'b0000110;
        4'h2:    return 7'b1011011;
        4'h3:    return 7'b1001111;
        4'h4:    return 7'b1100110;
        4'h5:    return 7'b1101101;
        4'h6:    return 7'b1111101;
        4'h7:    return 7'b0000111;
        4'h8:    return 7'b1111111;
        4'h9:    return 7'b1101111;
        4'ha:    return 7'b1110111;
        4'hb:    return 7'b1111100;
        4'hc:    return 7'b0111001;
        4'hd:    return 7'b1011110;
        4'he:    return 7'b1111001;
        default: return 7'b1110001;
    endcase
endfunction

function automatic rv_pkg::word_t model_alu(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// architectural run from pc 0 until a jump to itself, queues every port store
task automatic model_run(input rv_pkg::word_t img [0:`RV_IMEM_WORDS-1],
                         ref logic [15:0] outq [$], output bit done);
    rv_pkg::word_t    xr [0:31];
    rv_pkg::word_t    pc;
    rv_pkg::word_t    ins;
    rv_pkg::word_t    a;
    rv_pkg::word_t    b;
    rv_pkg::word_t    imm_i;
    rv_pkg::word_t    nxt;
    rv_pkg::word_t    val;
    rv_pkg::reg_idx_t rd;
    logic             wr;
    int               steps;
    for (steps = 0; steps < 32; steps++) begin
        xr[steps] = '0;
    end
    pc = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 4096) begin
        ins = img[pc[`RV_IMEM_AW+1:2]];
        a = xr[ins[19:15]];
        b = xr[ins[24:20]];
        rd = ins[11:7];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        nxt = pc + 32'd4;
        wr = 1'b1;
        val = '0;
        case (ins[6:0])
            `RV_OP_R:     val = model_alu(ins[14:12], ins[30], a, b);
            `RV_OP_I:     val = model_alu(ins[14:12], 1'b0, a, imm_i);
            `RV_OP_LUI:   val = {ins[31:12], 12'b0};
            `RV_OP_AUIPC: val = pc + {ins[31:12], 12'b0};
            `RV_OP_JAL: begin
                val = nxt;
                nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            `RV_OP_JALR: begin
                val = nxt;
                nxt = (a + imm_i) & ~32'd1;
            end
            `RV_OP_BR: begin
                wr = 1'b0;
                if ((a == b) != ins[12]) begin
                    nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            `RV_OP_ST: begin
                wr = 1'b0;
                if ((a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) == `RV_IO_ADDR) begin
                    outq.push_back(b[15:0]);
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            xr[rd] = val;
        end
        if (nxt == pc) begin
            done = 1'b1;
        end
        pc = nxt;
        steps++;
    end
endtask

`endif

// File: bench/tb_rv_soc.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module tb_rv_soc;

    localparam int n_programs  = 8;
    localparam int ack_limit   = 16;
    localparam int store_limit = 400;

    logic                   clk;
    logic                   rst;
    logic                   run;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`RV_IMEM_AW-1:0] wb_adr;
    rv_pkg::word_t          wb_dat_w;
    rv_pkg::word_t          wb_dat_r;
    logic                   wb_ack;
    rv_pkg::word_t          pc;
    logic [15:0]            io_data;
    logic                   io_valid;
    logic [6:0]             seg_0;
    logic [6:0]             seg_1;
    logic [6:0]             seg_2;
    logic [6:0]             seg_3;
    logic [6:0]             seg_pc_lo;
    logic [6:0]             seg_pc_hi;

    int            seed;
    int            prog_len;
    int            p;
    rv_pkg::word_t prog [0:`RV_IMEM_WORDS-1];

`include "rv_model.svh"

    rv_soc uut (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .pc        (pc),
        .io_data   (io_data),
        .io_valid  (io_valid),
        .seg_0     (seg_0),
        .seg_1     (seg_1),
        .seg_2     (seg_2),
        .seg_3     (seg_3),
        .seg_pc_lo (seg_pc_lo),
        .seg_pc_hi (seg_pc_hi)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_io(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_seg(input logic [6:0] got, input logic [6:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input rv_pkg::word_t got, input rv_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    function automatic int rnd(input int range);
        return int'($unsigned($random(seed)) % range);
    endfunction

    function automatic void put_word(input rv_pkg::word_t w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    // one classic cycle while the core is halted
    task automatic wb_access(input logic we, input logic [`RV_IMEM_AW-1:0] adr,
                             input rv_pkg::word_t wdata, output rv_pkg::word_t rdata);
        int waited;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        waited = 0;
        do begin
            @(negedge clk);
            check_word(pc, '0, "pc while halted");
            check_bit(io_valid, 1'b0, "io_valid while halted");
            waited++;
            if (!wb_ack && waited > ack_limit) begin
                abort_run("timed out waiting for wb_ack");
            end
        end while (!wb_ack);
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(negedge clk);
        check_bit(wb_ack, 1'b0, "wb_ack in the cycle after its access");
    endtask

    task automatic build_program();
        int               body_end;
        int               kind;
        int               k;
        int               r;
        int               reach;
        logic [2:0]       f3;
        rv_pkg::reg_idx_t rd;
        rv_pkg::reg_idx_t rs1;
        rv_pkg::reg_idx_t rs2;
        rv_pkg::reg_idx_t last_rd;
        prog_len = 0;
        reach = 0;
        // registers start out unknown so each gets a value
        for (r = 1; r < 32; r++) begin
            put_word(enc_i(3'd0, 5'(r), 5'd0, 12'(rnd(4096)), `RV_OP_I));
        end
        last_rd = 5'd31;
        body_end = prog_len + 40 + rnd(21);
        while (prog_len < body_end) begin
            kind = rnd(10);
            rd = 5'(rnd(32));
            rs1 = (rnd(2) == 1) ? last_rd : 5'(rnd(32));
            rs2 = (rnd(2) == 1) ? last_rd : 5'(rnd(32));
            k = 1 + rnd(4);
            if (prog_len + k > body_end) begin
                k = body_end - prog_len;
            end
            // a jalr that is a jump target would run without its auipc
            if (kind == 8 && (prog_len + 1 >= body_end || prog_len + 1 <= reach)) begin
                kind = 0;
            end
            case (kind)
                0, 1, 2: begin
                    f3 = 3'(rnd(8));
                    put_word(enc_r(f3, (f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1,
                                   rd, rs1, rs2));
                end
                3, 4: begin
                    f3 = 3'(rnd(8));
                    // only addi, slti, xori, ori, andi
                    if (f3 == 3'd1 || f3 == 3'd3 || f3 == 3'd5) begin
                        f3 = 3'd0;
                    end
                    put_word(enc_i(f3, rd, rs1, 12'(rnd(4096)), `RV_OP_I));
                end
                5: put_word(enc_u((rnd(2) == 1) ? `RV_OP_LUI : `RV_OP_AUIPC, rd,
                                  20'(rnd(1 << 20))));
                6: begin
                    reach = (prog_len + k > reach) ? prog_len + k : reach;
                    put_word(enc_b(rnd(2) == 1, rs1, (rnd(2) == 1) ? rs1 : rs2, 13'(4 * k)));
                end
                7: begin
                    reach = (prog_len + k > reach) ? prog_len + k : reach;
                    put_word(enc_j(rd, 21'(4 * k)));
                end
                8: begin
                    // auipc base plus jalr offset lands 0 to 3 words past the pair
                    k = rnd(4);
                    if (prog_len + 2 + k > body_end) begin
                        k = body_end - prog_len - 2;
                    end
                    reach = prog_len + 2 + k;
                    rs1 = 5'(1 + rnd(31));
                    put_word(enc_u(`RV_OP_AUIPC, rs1, 20'd0));
                    put_word(enc_i(3'd0, rd, rs1, 12'(8 + 4 * k), `RV_OP_JALR));
                end
                default: begin
                    if (rnd(2) == 1) begin
                        put_word(enc_s(5'd0, rs2, 12'h100));
                    end else begin
                        put_word(enc_s(rs1, rs2, 12'(4 * rnd(64))));
                    end
                end
            endcase
            last_rd = rd;
        end
        for (r = 1; r < 32; r++) begin
            put_word(enc_s(5'd0, 5'(r), 12'h100));
        end
        put_word(enc_j(5'd0, 21'd0));
    endtask

    task automatic load_program();
        int            i;
        rv_pkg::word_t rdata;
        for (i = 0; i < prog_len; i++) begin
            wb_access(1'b1, `RV_IMEM_AW'(i), prog[i], rdata);
        end
        for (i = 0; i < prog_len; i++) begin
            wb_access(1'b0, `RV_IMEM_AW'(i), '0, rdata);
            check_word(rdata, prog[i], "wishbone read-back");
        end
    endtask

    task automatic run_program();
        logic [15:0] expq [$];
        logic [15:0] e;
        bit          done;
        int          idle;
        model_run(prog, expq, done);
        if (!done) begin
            abort_run("reference model never reached the final jump");
        end
        @(negedge clk);
        run = 1'b1;
        idle = 0;
        while (expq.size() > 0) begin
            @(negedge clk);
            check_seg(seg_pc_lo, seg_code(pc[5:2]), "seg_pc_lo");
            check_seg(seg_pc_hi, seg_code(pc[9:6]), "seg_pc_hi");
            if (io_valid) begin
                e = expq.pop_front();
                check_io(io_data, e, "io_data");
                check_seg(seg_0, seg_code(e[3:0]), "seg_0");
                check_seg(seg_1, seg_code(e[7:4]), "seg_1");
                check_seg(seg_2, seg_code(e[11:8]), "seg_2");
                check_seg(seg_3, seg_code(e[15:12]), "seg_3");
                idle = 0;
            end else begin
                idle++;
                if (idle > store_limit) begin
                    abort_run("timed out waiting for an io_valid pulse");
                end
            end
        end
        // core spins on its last jump so no further stores may show up
        repeat (20) begin
            @(negedge clk);
            check_bit(io_valid, 1'b0, "io_valid after the last store");
        end
        run = 1'b0;
    endtask

    initial begin
        seed = 32'hdb7a;
        rst = 1'b1;
        run = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (p = 0; p < n_programs; p++) begin
            build_program();
            load_program();
            run_program();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_soc.f
+incdir+src
+incdir+bench
src/rv_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/regfile_fwd.sv
src/alu.sv
src/io_port.sv
src/rv_soc.sv
bench/tb_rv_soc.sv

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_pkg::word_t    a,
    input  wire rv_pkg::word_t    b,
    input  wire rv_pkg::alu_op_t  op,
    output rv_pkg::word_t         result,
    output logic                  equal
);

    logic [4:0] shamt;

    assign shamt = b[4:0];
    // branch compare for beq/bne
    assign equal = (a == b);

    always_comb begin
        case (op)
            rv_pkg::alu_add:    result = a + b;
            rv_pkg::alu_sub:    result = a - b;
            rv_pkg::alu_and:    result = a & b;
            rv_pkg::alu_or:     result = a | b;
            rv_pkg::alu_xor:    result = a ^ b;
            rv_pkg::alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::alu_sltu:   result = {31'b0, a < b};
            rv_pkg::alu_sll:    result = a << shamt;
            rv_pkg::alu_srl:    result = a >> shamt;
            rv_pkg::alu_sra:    result = $signed(a) >>> shamt;
            rv_pkg::alu_pass_b: result = b;
            default:            result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: src/decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module decoder (
    input  wire rv_pkg::word_t  instr,
    output rv_pkg::reg_idx_t    rs1,
    output rv_pkg::reg_idx_t    rs2,
    output rv_pkg::reg_idx_t    rd,
    output rv_pkg::word_t       imm,
    output rv_pkg::alu_op_t     alu_op,
    output logic                use_imm,
    output logic                reg_write,
    output logic                is_branch,
    output logic                branch_ne,
    output logic                is_jal,
    output logic                is_jalr,
    output logic                is_store,
    output logic                op1_pc,
    output logic                op1_zero
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    // funct3 plus the alternate bit (sub, sra) to an ALU operation
    function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  alu_sel = rv_pkg::alu_sll;
            3'b010:  alu_sel = rv_pkg::alu_slt;
            3'b011:  alu_sel = rv_pkg::alu_sltu;
            3'b100:  alu_sel = rv_pkg::alu_xor;
            3'b101:  alu_sel = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  alu_sel = rv_pkg::alu_or;
            default: alu_sel = rv_pkg::alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    always_comb begin
        imm       = '0;
        alu_op    = rv_pkg::alu_add;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_store  = 1'b0;
        op1_pc    = 1'b0;
        op1_zero  = 1'b0;
        case (opcode)
            `RV_OP_R: begin
                alu_op    = alu_sel(funct3, instr[30]);
                reg_write = 1'b1;
            end
            `RV_OP_I: begin
                imm       = {{20{instr[31]}}, instr[31:20]};
                // bit 30 only selects srai, addi never subtracts
                alu_op    = alu_sel(funct3, instr[30] & (funct3 == 3'b101));
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            `RV_OP_LUI: begin
                imm       = {instr[31:12], 12'b0};
                alu_op    = rv_pkg::alu_pass_b;
                use_imm   = 1'b1;
                op1_zero  = 1'b1;
                reg_write = 1'b1;
            end
            `RV_OP_AUIPC: begin
                imm       = {instr[31:12], 12'b0};
                use_imm   = 1'b1;
                op1_pc    = 1'b1;
                reg_write = 1'b1;
            end
            `RV_OP_JAL: begin
                imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
                is_jal    = 1'b1;
                reg_write = 1'b1;
            end
            `RV_OP_JALR: begin
                // alu sum rs1 + imm is the jump target
                imm       = {{20{instr[31]}}, instr[31:20]};
                use_imm   = 1'b1;
                is_jalr   = 1'b1;
                reg_write = 1'b1;
            end
            `RV_OP_BR: begin
                imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};
                alu_op    = rv_pkg::alu_sub;
                // only beq and bne
                is_branch = (funct3[2:1] == 2'b00);
                branch_ne = funct3[0];
            end
            `RV_OP_ST: begin
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm   = 1'b1;
                is_store  = (funct3 == 3'b010);
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module fetch_unit (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    run,
    input  wire                    redirect,
    input  wire rv_pkg::word_t     target,
    output rv_pkg::word_t          pc,
    output rv_pkg::word_t          instr,
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  wire [`RV_IMEM_AW-1:0]  wb_adr,
    input  wire rv_pkg::word_t     wb_dat_w,
    output rv_pkg::word_t          wb_dat_r,
    output logic                   wb_ack
);

    rv_pkg::word_t imem [0:`RV_IMEM_WORDS-1];
    logic          wb_hit;

    // instruction read is asynchronous, fetch and decode share one cycle
    assign instr = imem[pc[`RV_IMEM_AW+1:2]];

    // accept a new access only when no ack is pending
    assign wb_hit = wb_cyc & wb_stb & ~wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_hit && wb_we) begin
            imem[wb_adr] <= wb_dat_w;
        end
        if (wb_hit) begin
            wb_dat_r <= imem[wb_adr];
        end
    end

endmodule

`default_nettype wire

// File: src/io_port.sv
`timescale 1ns/1ps
`default_nettype none

module io_port (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 wr,
    input  wire rv_pkg::word_t  wr_data,
    input  wire rv_pkg::word_t  pc,
    output logic [15:0]         io_data,
    output logic                io_valid,
    output logic [6:0]          seg_0,
    output logic [6:0]          seg_1,
    output logic [6:0]          seg_2,
    output logic [6:0]          seg_3,
    output logic [6:0]          seg_pc_lo,
    output logic [6:0]          seg_pc_hi
);

    // hex digit to segments, bit 0 = a up to bit 6 = g, lit when high
    function automatic logic [6:0] hex7(input logic [3:0] nib);
        case (nib)
            4'h0:    hex7 = 7'h3f;
            4'h1:    hex7 = 7'h06;
            4'h2:    hex7 = 7'h5b;
            4'h3:    hex7 = 7'h4f;
            4'h4:    hex7 = 7'h66;
            4'h5:    hex7 = 7'h6d;
            4'h6:    hex7 = 7'h7d;
            4'h7:    hex7 = 7'h07;
            4'h8:    hex7 = 7'h7f;
            4'h9:    hex7 = 7'h6f;
            4'ha:    hex7 = 7'h77;
            4'hb:    hex7 = 7'h7c;
            4'hc:    hex7 = 7'h39;
            4'hd:    hex7 = 7'h5e;
            4'he:    hex7 = 7'h79;
            default: hex7 = 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            io_data  <= '0;
            io_valid <= 1'b0;
        end else begin
            io_valid <= wr;
            if (wr) begin
                io_data <= wr_data[15:0];
            end
        end
    end

    assign seg_0     = hex7(io_data[3:0]);
    assign seg_1     = hex7(io_data[7:4]);
    assign seg_2     = hex7(io_data[11:8]);
    assign seg_3     = hex7(io_data[15:12]);
    // word index of the fetch address
    assign seg_pc_lo = hex7(pc[5:2]);
    assign seg_pc_hi = hex7(pc[9:6]);

endmodule

`default_nettype wire

// File: src/regfile_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module regfile_fwd (
    input  wire                    clk,
    input  wire rv_pkg::reg_idx_t  rs1,
    input  wire rv_pkg::reg_idx_t  rs2,
    input  wire rv_pkg::reg_idx_t  wr_idx,
    input  wire rv_pkg::word_t     wr_data,
    input  wire                    wr_en,
    input  wire rv_pkg::reg_idx_t  x_rs1,
    input  wire rv_pkg::reg_idx_t  x_rs2,
    input  wire rv_pkg::word_t     x_rd1_raw,
    input  wire rv_pkg::word_t     x_rd2_raw,
    output rv_pkg::word_t          rd1,
    output rv_pkg::word_t          rd2,
    output rv_pkg::word_t          op1,
    output rv_pkg::word_t          op2
);

    rv_pkg::word_t    regs [0:31];
    rv_pkg::fwd_sel_t sel1;
    rv_pkg::fwd_sel_t sel2;

    function automatic rv_pkg::fwd_sel_t fwd_pick(input rv_pkg::reg_idx_t idx);
        if (idx == '0) begin
            fwd_pick = rv_pkg::fwd_zero;
        end else if (wr_en && (wr_idx == idx)) begin
            fwd_pick = rv_pkg::fwd_wb;
        end else begin
            fwd_pick = rv_pkg::fwd_rf;
        end
    endfunction

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_t sel,
                                              input rv_pkg::word_t raw);
        case (sel)
            rv_pkg::fwd_wb:   fwd_mux = wr_data;
            rv_pkg::fwd_zero: fwd_mux = '0;
            default:          fwd_mux = raw;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // decode read also bypasses the write landing this cycle
    assign rd1 = fwd_mux(fwd_pick(rs1), regs[rs1]);
    assign rd2 = fwd_mux(fwd_pick(rs2), regs[rs2]);

    // execute operands corrected from writeback
    assign sel1 = fwd_pick(x_rs1);
    assign sel2 = fwd_pick(x_rs2);
    assign op1  = fwd_mux(sel1, x_rd1_raw);
    assign op2  = fwd_mux(sel2, x_rd2_raw);

endmodule

`default_nettype wire

// File: src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// instruction memory, word addressed
`define RV_IMEM_WORDS 256
`define RV_IMEM_AW 8

// SW to this byte address drives the I/O register
`define RV_IO_ADDR 32'h0000_0100

// base opcodes, instr[6:0]
`define RV_OP_R 7'b0110011
`define RV_OP_I 7'b0010011
`define RV_OP_LUI 7'b0110111
`define RV_OP_AUIPC 7'b0010111
`define RV_OP_JAL 7'b1101111
`define RV_OP_JALR 7'b1100111
`define RV_OP_BR 7'b1100011
`define RV_OP_ST 7'b0100011

`endif

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // operation applied by the execute-stage ALU
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_t;

    // source of an execute operand
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_wb,
        fwd_zero
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: src/rv_soc.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rv_soc (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    run,
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  wire [`RV_IMEM_AW-1:0]  wb_adr,
    input  wire rv_pkg::word_t     wb_dat_w,
    output rv_pkg::word_t          wb_dat_r,
    output logic                   wb_ack,
    output rv_pkg::word_t          pc,
    output logic [15:0]            io_data,
    output logic                   io_valid,
    output logic [6:0]             seg_0,
    output logic [6:0]             seg_1,
    output logic [6:0]             seg_2,
    output logic [6:0]             seg_3,
    output logic [6:0]             seg_pc_lo,
    output logic [6:0]             seg_pc_hi
);

    // fetch/decode stage
    rv_pkg::word_t    instr;
    rv_pkg::word_t    d_imm;
    rv_pkg::word_t    d_rd1;
    rv_pkg::word_t    d_rd2;
    rv_pkg::reg_idx_t d_rs1;
    rv_pkg::reg_idx_t d_rs2;
    rv_pkg::reg_idx_t d_rd;
    rv_pkg::alu_op_t  d_alu_op;
    logic             d_use_imm;
    logic             d_reg_write;
    logic             d_is_branch;
    logic             d_branch_ne;
    logic             d_is_jal;
    logic             d_is_jalr;
    logic             d_is_store;
    logic             d_op1_pc;
    logic             d_op1_zero;

    // execute stage
    logic             x_valid;
    rv_pkg::word_t    x_pc;
    rv_pkg::word_t    x_pc4;
    rv_pkg::word_t    x_imm;
    rv_pkg::word_t    x_rd1_raw;
    rv_pkg::word_t    x_rd2_raw;
    rv_pkg::reg_idx_t x_rs1;
    rv_pkg::reg_idx_t x_rs2;
    rv_pkg::reg_idx_t x_rd;
    rv_pkg::alu_op_t  x_alu_op;
    logic             x_use_imm;
    logic             x_reg_write;
    logic             x_is_branch;
    logic             x_branch_ne;
    logic             x_is_jal;
    logic             x_is_jalr;
    logic             x_is_store;
    logic             x_op1_pc;
    logic             x_op1_zero;
    rv_pkg::word_t    x_op1;
    rv_pkg::word_t    x_op2;
    rv_pkg::word_t    alu_a;
    rv_pkg::word_t    alu_b;
    rv_pkg::word_t    alu_result;
    logic             alu_equal;
    logic             redirect;
    rv_pkg::word_t    target;
    logic             io_wr;

    // writeback stage
    logic             w_en;
    rv_pkg::reg_idx_t w_rd;
    rv_pkg::word_t    w_data;

    fetch_unit u_fetch (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .redirect (redirect),
        .target   (target),
        .pc       (pc),
        .instr    (instr),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    decoder u_dec (
        .instr     (instr),
        .rs1       (d_rs1),
        .rs2       (d_rs2),
        .rd        (d_rd),
        .imm       (d_imm),
        .alu_op    (d_alu_op),
        .use_imm   (d_use_imm),
        .reg_write (d_reg_write),
        .is_branch (d_is_branch),
        .branch_ne (d_branch_ne),
        .is_jal    (d_is_jal),
        .is_jalr   (d_is_jalr),
        .is_store  (d_is_store),
        .op1_pc    (d_op1_pc),
        .op1_zero  (d_op1_zero)
    );

    regfile_fwd u_rf (
        .clk       (clk),
        .rs1       (d_rs1),
        .rs2       (d_rs2),
        .wr_idx    (w_rd),
        .wr_data   (w_data),
        .wr_en     (w_en),
        .x_rs1     (x_rs1),
        .x_rs2     (x_rs2),
        .x_rd1_raw (x_rd1_raw),
        .x_rd2_raw (x_rd2_raw),
        .rd1       (d_rd1),
        .rd2       (d_rd2),
        .op1       (x_op1),
        .op2       (x_op2)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            x_valid <= 1'b0;
        end else begin
            // a taken branch or jump squashes the instruction behind it
            x_valid <= run & ~redirect;
        end
    end

    always_ff @(posedge clk) begin
        x_pc        <= pc;
        x_pc4       <= pc + 32'd4;
        x_imm       <= d_imm;
        x_rd1_raw   <= d_rd1;
        x_rd2_raw   <= d_rd2;
        x_rs1       <= d_rs1;
        x_rs2       <= d_rs2;
        x_rd        <= d_rd;
        x_alu_op    <= d_alu_op;
        x_use_imm   <= d_use_imm;
        x_reg_write <= d_reg_write;
        x_is_branch <= d_is_branch;
        x_branch_ne <= d_branch_ne;
        x_is_jal    <= d_is_jal;
        x_is_jalr   <= d_is_jalr;
        x_is_store  <= d_is_store;
        x_op1_pc    <= d_op1_pc;
        x_op1_zero  <= d_op1_zero;
    end

    assign alu_a = x_op1_pc ? x_pc : (x_op1_zero ? '0 : x_op1);
    assign alu_b = x_use_imm ? x_imm : x_op2;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (x_alu_op),
        .result (alu_result),
        .equal  (alu_equal)
    );

    assign redirect = x_valid & (x_is_jal | x_is_jalr |
                                 (x_is_branch & (alu_equal ^ x_branch_ne)));
    assign target   = x_is_jalr ? {alu_result[31:1], 1'b0} : x_pc + x_imm;
    // store data is rs2, the address comes out of the alu
    assign io_wr    = x_valid & x_is_store & (alu_result == `RV_IO_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            w_en <= 1'b0;
        end else begin
            w_en <= x_valid & x_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        w_rd   <= x_rd;
        w_data <= (x_is_jal | x_is_jalr) ? x_pc4 : alu_result;
    end

    io_port u_io (
        .clk       (clk),
        .rst       (rst),
        .wr        (io_wr),
        .wr_data   (x_op2),
        .pc        (pc),
        .io_data   (io_data),
        .io_valid  (io_valid),
        .seg_0     (seg_0),
        .seg_1     (seg_1),
        .seg_2     (seg_2),
        .seg_3     (seg_3),
        .seg_pc_lo (seg_pc_lo),
        .seg_pc_hi (seg_pc_hi)
    );

endmodule

`default_nettype wire
